/* vlog.f */
design/su_adder_pkg.sv
design/psum_reduce_tree.sv
design/beat_sequencer.sv
design/gbf_word_packer.sv
design/su_adder_top.sv
sim/su_adder_sva.sv
sim/su_adder_tb.sv

/* sim/su_adder_tb.sv */
`timescale 1ns/10ps

module su_adder_tb;

    import su_adder_pkg::*;

    localparam int n_pe      = 64;
    localparam int gbf_lanes = 8;
    localparam int gbf_depth = 32;
    localparam int addr_w    = $clog2(gbf_depth);
    localparam int n_rows    = 7;
    localparam int wd_cycles = n_rows * 40 + 50;

    typedef struct {
        group_e grp;
        bit     sat;     // every psum 16'hffff instead of random
        int     writes;  // gbf words expected per run
    } row_t;

    logic                  clk;
    logic                  reset;
    logic                  pe_psum_finish;
    group_e                group_sel;
    psum_t [n_pe-1:0]      psum_out;
    rf_addr_t              psum_rf_addr;
    logic                  su_add_finish;
    psum_t [gbf_lanes-1:0] out_data;
    logic                  psum_gbf_w_en;
    logic [addr_w-1:0]     psum_gbf_w_addr;
    logic                  psum_gbf_w_num;

    psum_t [n_pe-1:0]  rf_mem [rf_depth];  // PE register file, one vector per rf address
    int                seed = 32'haeb;
    logic [addr_w-1:0] exp_addr;           // write address and bank carried across runs
    logic              exp_bank;

    // 72 writes in all, so the address wraps twice
    row_t rows [n_rows] = '{
        '{group2, 1'b0, 16},
        '{group4, 1'b0, 8},
        '{group8, 1'b0, 4},
        '{group8, 1'b1, 4},   // 8 x 16'hffff wraps to 16'hfff8
        '{group2, 1'b1, 16},
        '{group4, 1'b0, 8},
        '{group2, 1'b0, 16}
    };

    su_adder_top i_su_adder_top (
        .clk             (clk),
        .reset           (reset),
        .pe_psum_finish  (pe_psum_finish),
        .group_sel       (group_sel),
        .psum_out        (psum_out),
        .psum_rf_addr    (psum_rf_addr),
        .su_add_finish   (su_add_finish),
        .out_data        (out_data),
        .psum_gbf_w_en   (psum_gbf_w_en),
        .psum_gbf_w_addr (psum_gbf_w_addr),
        .psum_gbf_w_num  (psum_gbf_w_num)
    );

    assign psum_out = rf_mem[psum_rf_addr];  // RF read in the same cycle

    always #5 clk = ~clk;

    task automatic stop_on_error();
        $display("TEST FAIL");
        $fatal(1, "stopped at the first error");
    endtask

    task automatic check_psum(input string name, input psum_t exp, input psum_t act);
        if (exp !== act) begin
            $display("** Error: %s expected %h got %h", name, exp, act);
            stop_on_error();
        end
    endtask

    task automatic check_group(input string name, input group_e exp, input group_e act);
        if (exp !== act) begin
            $display("** Error: %s expected %h got %h", name, exp, act);
            stop_on_error();
        end
    endtask

    task automatic check_rf_addr(input string name, input rf_addr_t exp, input rf_addr_t act);
        if (exp !== act) begin
            $display("** Error: %s expected %h got %h", name, exp, act);
            stop_on_error();
        end
    endtask

    task automatic check_gbf_addr(input string name, input logic [addr_w-1:0] exp,
                                  input logic [addr_w-1:0] act);
        if (exp !== act) begin
            $display("** Error: %s expected %h got %h", name, exp, act);
            stop_on_error();
        end
    endtask

    task automatic check_bit(input string name, input logic exp, input logic act);
        if (exp !== act) begin
            $display("** Error: %s expected %h got %h", name, exp, act);
            stop_on_error();
        end
    endtask

    task automatic next_cycle();
        @(posedge clk);
        #1;  // inputs change and outputs are read just after the edge
    endtask

    function automatic int group_size(group_e g);
        case (g)
            group2:  return 2;
            group4:  return 4;
            default: return 8;
        endcase
    endfunction

    // PEs s*g to s*g+g-1 of one rf address, wrapping at 16 bits
    function automatic psum_t group_sum(int rf, int s, int g);
        psum_t acc;
        acc = '0;
        for (int p = s * g; p < s * g + g; p++)
            acc = acc + rf_mem[rf][p];
        return acc;
    endfunction

    task automatic fill_rf(input bit sat);
        for (int a = 0; a < rf_depth; a++)
            for (int p = 0; p < n_pe; p++)
                rf_mem[a][p] = sat ? 16'hffff : psum_t'($random(seed));
    endtask

    // beat m of a run, address-major, lane 0 holds the lowest group
    task automatic check_word(input int m, input int g);
        int bpa;
        int rf;
        int bi;
        bpa = n_pe / (g * gbf_lanes);
        rf  = m / bpa;
        bi  = m % bpa;
        for (int l = 0; l < gbf_lanes; l++)
            check_psum($sformatf("out_data[%0d]", l), group_sum(rf, bi * gbf_lanes + l, g),
                       out_data[l]);
        check_gbf_addr("psum_gbf_w_addr", exp_addr, psum_gbf_w_addr);
        check_bit("psum_gbf_w_num", exp_bank, psum_gbf_w_num);
        if (exp_addr == addr_w'(gbf_depth - 1))
            exp_bank = ~exp_bank;
        exp_addr = exp_addr + 1'b1;
    endtask

    task automatic run_row(input row_t r);
        int g;
        int bpa;
        int n_beats;
        int c;
        int n_wr;
        g       = group_size(r.grp);
        bpa     = n_pe / (g * gbf_lanes);
        n_beats = rf_depth * bpa;
        fill_rf(r.sat);
        group_sel      = r.grp;
        pe_psum_finish = 1'b1;
        next_cycle();
        pe_psum_finish = 1'b0;
        c    = 0;
        n_wr = 0;
        forever begin
            check_group("group_q", r.grp, i_su_adder_top.group_q);
            check_bit("su_add_finish", c >= n_beats, su_add_finish);
            check_bit("psum_gbf_w_en", (c >= 1) && (c <= n_beats), psum_gbf_w_en);
            check_rf_addr("psum_rf_addr", rf_addr_t'((c < n_beats) ? c / bpa : 0),
                          psum_rf_addr);
            if (psum_gbf_w_en) begin
                check_word(n_wr, g);
                n_wr++;
            end
            if (su_add_finish)
                break;
            // second pulse with another group, the run must ignore it
            pe_psum_finish = (c == 1);
            group_sel      = (c == 1) ? ((r.grp == group8) ? group2 : group8) : r.grp;
            next_cycle();
            c++;
        end
        if (n_wr != r.writes) begin
            $display("run wrote %0d gbf words, %0d were expected", n_wr, r.writes);
            stop_on_error();
        end
        next_cycle();
        check_bit("psum_gbf_w_en", 1'b0, psum_gbf_w_en);
        check_bit("su_add_finish", 1'b1, su_add_finish);
    endtask

    initial begin
        clk            = 1'b0;
        reset          = 1'b1;
        pe_psum_finish = 1'b0;
        group_sel      = group2;
        exp_addr       = '0;
        exp_bank       = 1'b0;
        for (int a = 0; a < rf_depth; a++)
            rf_mem[a] = '0;
        repeat (5) @(posedge clk);
        #1;
        reset = 1'b0;
        next_cycle();

        // idle state right after reset
        check_bit("su_add_finish", 1'b1, su_add_finish);
        check_bit("psum_gbf_w_en", 1'b0, psum_gbf_w_en);
        check_rf_addr("psum_rf_addr", '0, psum_rf_addr);
        check_gbf_addr("psum_gbf_w_addr", '0, psum_gbf_w_addr);
        check_bit("psum_gbf_w_num", 1'b0, psum_gbf_w_num);
        for (int l = 0; l < gbf_lanes; l++)
            check_psum($sformatf("out_data[%0d]", l), '0, out_data[l]);

        for (int i = 0; i < n_rows; i++)
            run_row(rows[i]);

        if (i_su_adder_top.i_su_adder_sva.err_count != 0) begin
            $display("%0d assertion failures in the bound checker",
                     i_su_adder_top.i_su_adder_sva.err_count);
            $display("TEST FAIL");
            $fatal(1, "assertion failures");
        end else begin
            $display("TEST PASS");
            $finish;
        end
    end

    // watchdog
    initial begin
        repeat (wd_cycles) @(posedge clk);
        $display("timeout, the runs did not complete within %0d cycles", wd_cycles);
        $display("TEST FAIL");
        $fatal(1, "watchdog expired");
    end

endmodule

/* sim/su_adder_sva.sv */
`timescale 1ns/10ps

module su_adder_sva #(
    parameter int gbf_depth = 32
) (
    input logic                         clk,
    input logic                         reset,
    input logic                         su_add_finish,
    input logic                         psum_gbf_w_en,
    input logic [$clog2(gbf_depth)-1:0] psum_gbf_w_addr,
    input logic                         psum_gbf_w_num,
    input su_adder_pkg::rf_addr_t       psum_rf_addr
);

    import su_adder_pkg::*;

    seq_state_e state;          // run state seen through the finish level
    int         err_count = 0;

    assign state = su_add_finish ? idle : run;

    // the packer needs a cycle, so nothing is written right after idle
    a_no_early_write: assert property (@(posedge clk) disable iff (reset)
        $past(su_add_finish) |-> !psum_gbf_w_en)
    else begin
        $error("write strobe high one cycle after an idle cycle");
        err_count++;
    end

    a_bank_after_wrap: assert property (@(posedge clk) disable iff (reset)
        $changed(psum_gbf_w_num) |-> $past(psum_gbf_w_en && psum_gbf_w_addr == gbf_depth - 1))
    else begin
        $error("gbf bank toggled without a write at the last address");
        err_count++;
    end

    a_wrap_toggles: assert property (@(posedge clk) disable iff (reset)
        (psum_gbf_w_en && psum_gbf_w_addr == gbf_depth - 1) |=> $changed(psum_gbf_w_num))
    else begin
        $error("gbf bank kept after a write at the last address");
        err_count++;
    end

    a_rf_addr_in_run: assert property (@(posedge clk) disable iff (reset)
        $changed(psum_rf_addr) |-> $past(state == run))
    else begin
        $error("psum rf address moved while idle");
        err_count++;
    end

endmodule

bind su_adder_top su_adder_sva #(.gbf_depth(gbf_depth)) i_su_adder_sva (.*);

/* design/su_adder_top.sv */
`timescale 1ns/10ps

module su_adder_top #(
    parameter int n_pe      = 64,
    parameter int gbf_lanes = 8,
    parameter int gbf_depth = 32
) (
    input  logic                                clk,
    input  logic                                reset,
    input  logic                                pe_psum_finish,
    input  su_adder_pkg::group_e                group_sel,
    input  su_adder_pkg::psum_t [n_pe-1:0]      psum_out,
    output su_adder_pkg::rf_addr_t              psum_rf_addr,
    output logic                                su_add_finish,
    output su_adder_pkg::psum_t [gbf_lanes-1:0] out_data,
    output logic                                psum_gbf_w_en,
    output logic [$clog2(gbf_depth)-1:0]        psum_gbf_w_addr,
    output logic                                psum_gbf_w_num
);

    import su_adder_pkg::*;

    localparam int beat_w = beat_idx_w(n_pe, gbf_lanes);

    psum_t [n_pe/2-1:0] sum2;
    psum_t [n_pe/4-1:0] sum4;
    psum_t [n_pe/8-1:0] sum8;
    group_e             group_q;
    logic [beat_w-1:0]  beat_idx;
    logic               beat_valid;

    psum_reduce_tree #(.n_pe(n_pe)) i_psum_reduce_tree (
        .psum_out (psum_out),
        .sum2     (sum2),
        .sum4     (sum4),
        .sum8     (sum8)
    );

    beat_sequencer #(.n_pe(n_pe), .gbf_lanes(gbf_lanes), .gbf_depth(gbf_depth))
    i_beat_sequencer (
        .clk             (clk),
        .reset           (reset),
        .pe_psum_finish  (pe_psum_finish),
        .group_sel       (group_sel),
        .group_q         (group_q),
        .beat_idx        (beat_idx),
        .beat_valid      (beat_valid),
        .psum_rf_addr    (psum_rf_addr),
        .psum_gbf_w_addr (psum_gbf_w_addr),
        .psum_gbf_w_num  (psum_gbf_w_num),
        .su_add_finish   (su_add_finish)
    );

    // tree output is ready in the beat's own cycle, the packer registers it
    gbf_word_packer #(.n_pe(n_pe), .gbf_lanes(gbf_lanes)) i_gbf_word_packer (
        .clk           (clk),
        .reset         (reset),
        .sum2          (sum2),
        .sum4          (sum4),
        .sum8          (sum8),
        .group_q       (group_q),
        .beat_idx      (beat_idx),
        .beat_valid    (beat_valid),
        .out_data      (out_data),
        .psum_gbf_w_en (psum_gbf_w_en)
    );

endmodule

/* design/gbf_word_packer.sv */
`timescale 1ns/10ps

module gbf_word_packer #(
    parameter int n_pe      = 64,
    parameter int gbf_lanes = 8
) (
    input  logic                                                 clk,
    input  logic                                                 reset,
    input  su_adder_pkg::psum_t [n_pe/2-1:0]                     sum2,
    input  su_adder_pkg::psum_t [n_pe/4-1:0]                     sum4,
    input  su_adder_pkg::psum_t [n_pe/8-1:0]                     sum8,
    input  su_adder_pkg::group_e                                 group_q,
    input  logic [su_adder_pkg::beat_idx_w(n_pe, gbf_lanes)-1:0] beat_idx,
    input  logic                                                 beat_valid,
    output su_adder_pkg::psum_t [gbf_lanes-1:0]                  out_data,
    output logic                                                 psum_gbf_w_en
);

    import su_adder_pkg::*;

    psum_t [gbf_lanes-1:0] word_d;
    int                    base;   // first group sum of this beat

    assign base = int'(beat_idx) * gbf_lanes;

    // slice of the chosen tree level, lane 0 in the low bits
    always_comb begin
        for (int l = 0; l < gbf_lanes; l++) begin
            case (group_q)
                group2:  word_d[l] = sum2[base + l];
                group4:  word_d[l] = sum4[base + l];
                default: word_d[l] = sum8[base + l];
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            out_data      <= '0;
            psum_gbf_w_en <= 1'b0;
        end else begin
            psum_gbf_w_en <= beat_valid;
            if (beat_valid)
                out_data <= word_d;  // holds between beats
        end
    end

endmodule

/* design/beat_sequencer.sv */
`timescale 1ns/10ps

module beat_sequencer #(
    parameter int n_pe      = 64,
    parameter int gbf_lanes = 8,
    parameter int gbf_depth = 32
) (
    input  logic                                                 clk,
    input  logic                                                 reset,
    input  logic                                                 pe_psum_finish,
    input  su_adder_pkg::group_e                                 group_sel,
    output su_adder_pkg::group_e                                 group_q,
    output logic [su_adder_pkg::beat_idx_w(n_pe, gbf_lanes)-1:0] beat_idx,
    output logic                                                 beat_valid,
    output su_adder_pkg::rf_addr_t                               psum_rf_addr,
    output logic [$clog2(gbf_depth)-1:0]                         psum_gbf_w_addr,
    output logic                                                 psum_gbf_w_num,
    output logic                                                 su_add_finish
);

    import su_adder_pkg::*;

    localparam int beat_w    = beat_idx_w(n_pe, gbf_lanes);
    localparam int max_beats = n_pe / (2 * gbf_lanes);  // beats per address for group2
    localparam int addr_w    = $clog2(gbf_depth);

    seq_state_e        state;
    logic [beat_w-1:0] last_beat;     // index of the final beat of one rf address
    logic              last_in_addr;
    logic              last_in_run;
    logic              wr_q;          // mirrors the packer's write strobe

    // beats per address halve with each tree level
    always_comb begin
        case (group_q)
            group2:  last_beat = beat_w'(max_beats - 1);
            group4:  last_beat = beat_w'(max_beats / 2 - 1);
            default: last_beat = beat_w'(max_beats / 4 - 1);
        endcase
    end

    assign last_in_addr  = (beat_idx == last_beat);
    assign last_in_run   = last_in_addr && (psum_rf_addr == rf_addr_t'(rf_depth - 1));
    assign beat_valid    = (state == run);
    assign su_add_finish = (state == idle);

    always_ff @(posedge clk) begin
        if (reset) begin
            state        <= idle;
            group_q      <= group2;
            beat_idx     <= '0;
            psum_rf_addr <= '0;
        end else begin
            case (state)
                idle: begin
                    if (pe_psum_finish) begin
                        state    <= run;
                        group_q  <= group_sel;  // held for the whole run
                        beat_idx <= '0;
                    end
                end
                default: begin  // run, finish pulses are not looked at here
                    if (last_in_addr) begin
                        beat_idx <= '0;
                        if (last_in_run) begin
                            state        <= idle;
                            psum_rf_addr <= '0;
                        end else begin
                            psum_rf_addr <= psum_rf_addr + 1'b1;
                        end
                    end else begin
                        beat_idx <= beat_idx + 1'b1;
                    end
                end
            endcase
        end
    end

    // gbf write address, moves on after each written word
    always_ff @(posedge clk) begin
        if (reset) begin
            wr_q            <= 1'b0;
            psum_gbf_w_addr <= '0;
            psum_gbf_w_num  <= 1'b0;
        end else begin
            wr_q <= beat_valid;
            if (wr_q) begin
                if (psum_gbf_w_addr == addr_w'(gbf_depth - 1)) begin
                    psum_gbf_w_addr <= '0;
                    psum_gbf_w_num  <= ~psum_gbf_w_num;  // next bank
                end else begin
                    psum_gbf_w_addr <= psum_gbf_w_addr + 1'b1;
                end
            end
        end
    end

endmodule

/* design/psum_reduce_tree.sv */
`timescale 1ns/10ps

module psum_reduce_tree #(
    parameter int n_pe = 64
) (
    input  su_adder_pkg::psum_t [n_pe-1:0]   psum_out,
    output su_adder_pkg::psum_t [n_pe/2-1:0] sum2,
    output su_adder_pkg::psum_t [n_pe/4-1:0] sum4,
    output su_adder_pkg::psum_t [n_pe/8-1:0] sum8
);

    // every level is kept so the group size can switch per run
    // without touching the tree

    generate
        // level 1: neighbouring PE pairs
        for (genvar i = 0; i < n_pe/2; i++) begin : g_lvl1
            assign sum2[i] = psum_out[2*i] + psum_out[2*i+1];
        end

        // level 2: pairs of pair sums, 4 PEs each
        for (genvar j = 0; j < n_pe/4; j++) begin : g_lvl2
            assign sum4[j] = sum2[2*j] + sum2[2*j+1];  // wraps at 16 bits
        end

        // level 3: 8 PEs each
        for (genvar k = 0; k < n_pe/8; k++) begin : g_lvl3
            assign sum8[k] = sum4[2*k] + sum4[2*k+1];
        end
    endgenerate

endmodule

/* design/su_adder_pkg.sv */
package su_adder_pkg;

    // psum width and the number of rf addresses swept per run
    localparam int psum_w   = 16;
    localparam int rf_depth = 4;

    // one PE partial sum, additions wrap modulo 2^psum_w
    typedef logic [psum_w-1:0] psum_t;

    typedef logic [1:0] rf_addr_t;  // psum register-file address

    // irrelevant-operand group size
    typedef enum logic [1:0] {
        group2 = 2'd0,
        group4 = 2'd1,
        group8 = 2'd2
    } group_e;

    typedef enum logic {
        idle = 1'b0,
        run  = 1'b1
    } seq_state_e;

    // width of the beat index, sized for the smallest group
    function automatic int beat_idx_w(int n_pe, int gbf_lanes);
        int max_beats;
        max_beats = n_pe / (2 * gbf_lanes);
        return (max_beats > 1) ? $clog2(max_beats) : 1;
    endfunction

endpackage
